//--- include/pito_params.svh
`ifndef PITO_PARAMS_SVH
`define PITO_PARAMS_SVH

// ==============================
// hart configuration
// ==============================

// number of hardware threads, power of two and at least 4
`define PITO_NUM_HARTS 8
// width of a hart index
`define PITO_HART_BITS 3

// ==============================
// datapath widths
// ==============================

`define PITO_XLEN 32
// x0..x31 per hart
`define PITO_REG_ADDR_BITS 5

// ==============================
// instruction memory
// ==============================

// 32-bit words, shared by all harts
`define PITO_IMEM_WORDS 512
`define PITO_IMEM_ADDR_BITS 9
// hart base byte address is hart index << shift, 256 bytes each
`define PITO_HART_BASE_SHIFT 8

`endif

//--- hw/pito_pkg.sv
`default_nettype none

`include "pito_params.svh"

package pito_pkg;

    // ==============================
    // vector types
    // ==============================

    typedef logic [`PITO_HART_BITS-1:0]      hart_id_t;
    // byte addressed program counter
    typedef logic [`PITO_XLEN-1:0]           pc_t;
    typedef logic [31:0]                     instr_t;
    typedef logic [`PITO_REG_ADDR_BITS-1:0]  reg_addr_t;
    typedef logic [`PITO_XLEN-1:0]           xlen_t;
    // word index into instruction memory
    typedef logic [`PITO_IMEM_ADDR_BITS-1:0] imem_addr_t;

    // ==============================
    // decoded instructions
    // ==============================

    typedef enum logic [4:0] {
        // register-register
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
        OP_SLL, OP_SRL, OP_SRA, OP_SLT, OP_SLTU,
        // register-immediate
        OP_ADDI, OP_ANDI, OP_ORI, OP_XORI,
        OP_SLLI, OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU,
        // upper immediate, jump, branches
        OP_LUI, OP_JAL, OP_BEQ, OP_BNE,
        // anything else, retired as a no-op
        OP_ILLEGAL
    } opcode_e;

    // alu functions
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

endpackage

`default_nettype wire

//--- hw/pito_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "pito_params.svh"

module pito_fetch import pito_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    // programming port
    input  logic       imem_w_en,
    input  imem_addr_t imem_addr,
    input  instr_t     imem_data,
    // pc redirect from execute
    input  logic       pc_upd,
    input  hart_id_t   pc_hart,
    input  pc_t        pc_next,
    // to decoder and register file
    output logic       f_valid,
    output hart_id_t   f_hart,
    output pc_t        f_pc,
    output instr_t     f_instr
);

    hart_id_t   hart_cnt;
    pc_t        pc_q [`PITO_NUM_HARTS];
    instr_t     imem [`PITO_IMEM_WORDS];
    pc_t        sel_pc;
    imem_addr_t rd_addr;

    // ==============================
    // round-robin hart counter
    // ==============================

    // free running, wraps since hart count is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            hart_cnt <= '0;
        end else begin
            hart_cnt <= hart_cnt + 1'b1;
        end
    end

    // ==============================
    // per-hart program counters
    // ==============================

    // each hart starts at its own base
    // execute always supplies the next pc, no +4 here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PITO_NUM_HARTS; i++) begin
                pc_q[i] <= pc_t'(i << `PITO_HART_BASE_SHIFT);
            end
        end else if (pc_upd) begin
            pc_q[pc_hart] <= pc_next;
        end
    end

    assign sel_pc  = pc_q[hart_cnt];
    // word address, low two bits dropped
    assign rd_addr = sel_pc[`PITO_IMEM_ADDR_BITS+1:2];

    // ==============================
    // instruction memory
    // ==============================

    // write from the port, synchronous read for the scheduled hart
    always_ff @(posedge clk) begin
        if (imem_w_en) begin
            imem[imem_addr] <= imem_data;
        end
        f_instr <= imem[rd_addr];
        f_hart  <= hart_cnt;
        f_pc    <= sel_pc;
    end

    // bubble whenever the core is held
    always_ff @(posedge clk) begin
        if (rst) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= run;
        end
    end

endmodule

`default_nettype wire

//--- hw/pito_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pito_decoder import pito_pkg::*; (
    input  instr_t    instr,
    output opcode_e   opcode,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output xlen_t     imm,
    output alu_op_e   alu_op,
    output logic      use_imm
);

    logic [6:0] major;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_u;
    xlen_t      imm_b;
    xlen_t      imm_j;
    xlen_t      shamt;

    // fixed field positions
    assign major  = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    // ==============================
    // immediates
    // ==============================

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    // shift amount, zero extended
    assign shamt = xlen_t'(instr[24:20]);

    // ==============================
    // opcode
    // ==============================

    always_comb begin
        opcode = OP_ILLEGAL;
        case (major)
            // register-register, funct7 picks sub and sra
            7'b0110011: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: opcode = OP_ADD;
                    {7'h20, 3'b000}: opcode = OP_SUB;
                    {7'h00, 3'b001}: opcode = OP_SLL;
                    {7'h00, 3'b010}: opcode = OP_SLT;
                    {7'h00, 3'b011}: opcode = OP_SLTU;
                    {7'h00, 3'b100}: opcode = OP_XOR;
                    {7'h00, 3'b101}: opcode = OP_SRL;
                    {7'h20, 3'b101}: opcode = OP_SRA;
                    {7'h00, 3'b110}: opcode = OP_OR;
                    {7'h00, 3'b111}: opcode = OP_AND;
                    default:         opcode = OP_ILLEGAL;
                endcase
            end
            // register-immediate
            7'b0010011: begin
                case (funct3)
                    3'b000:  opcode = OP_ADDI;
                    3'b010:  opcode = OP_SLTI;
                    3'b011:  opcode = OP_SLTIU;
                    3'b100:  opcode = OP_XORI;
                    3'b110:  opcode = OP_ORI;
                    3'b111:  opcode = OP_ANDI;
                    3'b001:  opcode = (funct7 == 7'h00) ? OP_SLLI : OP_ILLEGAL;
                    default: opcode = (funct7 == 7'h00) ? OP_SRLI :
                                      (funct7 == 7'h20) ? OP_SRAI : OP_ILLEGAL;
                endcase
            end
            7'b0110111: opcode = OP_LUI;
            7'b1101111: opcode = OP_JAL;
            // only beq and bne kept
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    opcode = OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    opcode = OP_BNE;
                end
            end
            default: opcode = OP_ILLEGAL;
        endcase
    end

    // ==============================
    // alu function and operand b
    // ==============================

    always_comb begin
        case (opcode)
            OP_SUB:            alu_op = ALU_SUB;
            OP_AND, OP_ANDI:   alu_op = ALU_AND;
            OP_OR, OP_ORI:     alu_op = ALU_OR;
            OP_XOR, OP_XORI:   alu_op = ALU_XOR;
            OP_SLL, OP_SLLI:   alu_op = ALU_SLL;
            OP_SRL, OP_SRLI:   alu_op = ALU_SRL;
            OP_SRA, OP_SRAI:   alu_op = ALU_SRA;
            OP_SLT, OP_SLTI:   alu_op = ALU_SLT;
            OP_SLTU, OP_SLTIU: alu_op = ALU_SLTU;
            default:           alu_op = ALU_ADD;
        endcase
    end

    assign use_imm = opcode inside {OP_ADDI, OP_ANDI, OP_ORI, OP_XORI, OP_SLLI,
                                    OP_SRLI, OP_SRAI, OP_SLTI, OP_SLTIU};

    // immediate by format
    always_comb begin
        case (opcode)
            OP_LUI:                    imm = imm_u;
            OP_JAL:                    imm = imm_j;
            OP_BEQ, OP_BNE:            imm = imm_b;
            OP_SLLI, OP_SRLI, OP_SRAI: imm = shamt;
            default:                   imm = imm_i;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/pito_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "pito_params.svh"

module pito_regfile import pito_pkg::*; (
    input  logic      clk,
    // read side, hart in decode
    input  hart_id_t  r_hart,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    output xlen_t     rd1,
    output xlen_t     rd2,
    // write side, hart in writeback
    input  logic      wen,
    input  hart_id_t  w_hart,
    input  reg_addr_t wa,
    input  xlen_t     wd
);

    localparam int NUM_REGS = 1 << `PITO_REG_ADDR_BITS;

    // ==============================
    // banked storage
    // ==============================

    // one bank of 32 registers per hart
    xlen_t regs [`PITO_NUM_HARTS][NUM_REGS];

    // x0 never written
    always_ff @(posedge clk) begin
        if (wen) begin
            regs[w_hart][wa] <= wd;
        end
    end

    // combinational reads, x0 forced to zero
    assign rd1 = (ra1 == '0) ? '0 : regs[r_hart][ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[r_hart][ra2];

endmodule

`default_nettype wire

//--- hw/pito_execute.sv
`timescale 1ns/1ps
`default_nettype none

module pito_execute import pito_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    // decoded instruction
    input  logic      d_valid,
    input  hart_id_t  d_hart,
    input  pc_t       d_pc,
    input  opcode_e   opcode,
    input  alu_op_e   alu_op,
    input  logic      use_imm,
    input  reg_addr_t rd,
    input  xlen_t     imm,
    input  xlen_t     rs1_val,
    input  xlen_t     rs2_val,
    // register file write
    output logic      wen,
    output hart_id_t  w_hart,
    output reg_addr_t wa,
    output xlen_t     wd,
    output pc_t       w_pc,
    // pc redirect to fetch
    output logic      pc_upd,
    output hart_id_t  pc_hart,
    output pc_t       pc_next
);

    xlen_t    op_b;
    xlen_t    alu_res;
    xlen_t    wb_data;
    pc_t      pc_plus4;
    pc_t      pc_target;
    pc_t      next_pc;
    logic     taken;
    logic     writes_rd;
    hart_id_t hart_q;

    // ==============================
    // alu
    // ==============================

    assign op_b = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            ALU_SUB:  alu_res = rs1_val - op_b;
            ALU_AND:  alu_res = rs1_val & op_b;
            ALU_OR:   alu_res = rs1_val | op_b;
            ALU_XOR:  alu_res = rs1_val ^ op_b;
            // shifts use low five bits only
            ALU_SLL:  alu_res = rs1_val << op_b[4:0];
            ALU_SRL:  alu_res = rs1_val >> op_b[4:0];
            ALU_SRA:  alu_res = xlen_t'($signed(rs1_val) >>> op_b[4:0]);
            ALU_SLT:  alu_res = xlen_t'($signed(rs1_val) < $signed(op_b));
            ALU_SLTU: alu_res = xlen_t'(rs1_val < op_b);
            default:  alu_res = rs1_val + op_b;
        endcase
    end

    // ==============================
    // branch and next pc
    // ==============================

    // branches compare the two registers directly
    assign taken = ((opcode == OP_BEQ) && (rs1_val == rs2_val)) ||
                   ((opcode == OP_BNE) && (rs1_val != rs2_val));

    assign pc_plus4  = d_pc + 32'd4;
    assign pc_target = d_pc + imm;
    assign next_pc   = ((opcode == OP_JAL) || taken) ? pc_target : pc_plus4;

    // branches and illegal words leave the registers alone
    assign writes_rd = !(opcode inside {OP_BEQ, OP_BNE, OP_ILLEGAL}) && (rd != '0);

    // lui takes imm, jal saves return address
    always_comb begin
        case (opcode)
            OP_LUI:  wb_data = imm;
            OP_JAL:  wb_data = pc_plus4;
            default: wb_data = alu_res;
        endcase
    end

    // ==============================
    // writeback register
    // ==============================

    always_ff @(posedge clk) begin
        if (rst) begin
            wen    <= 1'b0;
            pc_upd <= 1'b0;
        end else begin
            wen    <= d_valid && writes_rd;
            // every valid instruction moves its hart's pc
            pc_upd <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        hart_q  <= d_hart;
        wa      <= rd;
        wd      <= wb_data;
        w_pc    <= d_pc;
        pc_next <= next_pc;
    end

    // same hart for both writes
    assign w_hart  = hart_q;
    assign pc_hart = hart_q;

endmodule

`default_nettype wire

//--- hw/pito_core.sv
`timescale 1ns/1ps
`default_nettype none

module pito_core import pito_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    input  logic       imem_w_en,
    input  imem_addr_t imem_addr,
    input  instr_t     imem_data,
    // one entry per register write
    output logic       retire_valid,
    output hart_id_t   retire_hart,
    output pc_t        retire_pc,
    output reg_addr_t  retire_rd,
    output xlen_t      retire_data
);

    // fetch to decode
    logic      f_valid;
    hart_id_t  f_hart;
    pc_t       f_pc;
    instr_t    f_instr;
    // decoder outputs
    opcode_e   opcode;
    alu_op_e   alu_op;
    logic      use_imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    xlen_t     imm;
    xlen_t     rd1;
    xlen_t     rd2;
    // writeback and redirect
    logic      wen;
    hart_id_t  w_hart;
    reg_addr_t wa;
    xlen_t     wd;
    pc_t       w_pc;
    logic      pc_upd;
    hart_id_t  pc_hart;
    pc_t       pc_next;

    // ==============================
    // pipeline
    // ==============================

    pito_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .run       (run),
        .imem_w_en (imem_w_en),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .pc_upd    (pc_upd),
        .pc_hart   (pc_hart),
        .pc_next   (pc_next),
        .f_valid   (f_valid),
        .f_hart    (f_hart),
        .f_pc      (f_pc),
        .f_instr   (f_instr)
    );

    pito_decoder u_decoder (
        .instr   (f_instr),
        .opcode  (opcode),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .imm     (imm),
        .alu_op  (alu_op),
        .use_imm (use_imm)
    );

    // read bank of the decoding hart, write bank of the retiring one
    pito_regfile u_regfile (
        .clk    (clk),
        .r_hart (f_hart),
        .ra1    (rs1),
        .ra2    (rs2),
        .rd1    (rd1),
        .rd2    (rd2),
        .wen    (wen),
        .w_hart (w_hart),
        .wa     (wa),
        .wd     (wd)
    );

    pito_execute u_execute (
        .clk     (clk),
        .rst     (rst),
        .d_valid (f_valid),
        .d_hart  (f_hart),
        .d_pc    (f_pc),
        .opcode  (opcode),
        .alu_op  (alu_op),
        .use_imm (use_imm),
        .rd      (rd),
        .imm     (imm),
        .rs1_val (rd1),
        .rs2_val (rd2),
        .wen     (wen),
        .w_hart  (w_hart),
        .wa      (wa),
        .wd      (wd),
        .w_pc    (w_pc),
        .pc_upd  (pc_upd),
        .pc_hart (pc_hart),
        .pc_next (pc_next)
    );

    // retire port mirrors the register file write
    assign retire_valid = wen;
    assign retire_hart  = w_hart;
    assign retire_pc    = w_pc;
    assign retire_rd    = wa;
    assign retire_data  = wd;

endmodule

`default_nettype wire

//--- verif/pito_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "pito_params.svh"

module pito_core_properties import pito_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      run,
    input logic      retire_valid,
    input hart_id_t  retire_hart,
    input pc_t       retire_pc,
    input reg_addr_t retire_rd,
    input xlen_t     retire_data
);

    // count of failed assertions, polled by the testbench
    int assert_fails = 0;

    // ==============================
    // retire port rules
    // ==============================

    // held core, run low reaches writeback two edges later
    idle_no_retire: assert property (@(posedge clk) disable iff (rst)
        !run |-> ##2 !retire_valid)
        else begin
            $error("retire_valid high while run was low");
            assert_fails++;
        end

    // back to back retires come from successive harts
    hart_round_robin: assert property (@(posedge clk) disable iff (rst)
        retire_valid && $past(retire_valid) |->
            retire_hart == hart_id_t'($past(retire_hart) + 1'b1))
        else begin
            $error("retire_hart did not advance by one");
            assert_fails++;
        end

    // x0 never written
    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rd != '0)
        else begin
            $error("retire with rd equal to x0");
            assert_fails++;
        end

    // same pc one hart turn apart, only a jump to itself does that
    jal_self_loop: assert property (@(posedge clk) disable iff (rst)
        retire_valid && $past(retire_valid, `PITO_NUM_HARTS) &&
        retire_hart == $past(retire_hart, `PITO_NUM_HARTS) &&
        retire_pc == $past(retire_pc, `PITO_NUM_HARTS) |->
            retire_data == retire_pc + 32'd4)
        else begin
            $error("jal return address is not pc plus 4");
            assert_fails++;
        end

endmodule

`default_nettype wire

//--- verif/pito_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pito_params.svh"

module pito_core_tb import pito_pkg::*; ();

    localparam int EXP_DEPTH      = 64;
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       rst;
    logic       run;
    logic       imem_w_en;
    imem_addr_t imem_addr;
    instr_t     imem_data;
    logic       retire_valid;
    hart_id_t   retire_hart;
    pc_t        retire_pc;
    reg_addr_t  retire_rd;
    xlen_t      retire_data;

    integer seed = 32'h57e;
    // generator state of the hart being built
    pc_t   gen_pc;
    xlen_t mreg [32];
    // expected retires per hart in retire order
    pc_t       exp_pc   [`PITO_NUM_HARTS][EXP_DEPTH];
    reg_addr_t exp_rd   [`PITO_NUM_HARTS][EXP_DEPTH];
    xlen_t     exp_data [`PITO_NUM_HARTS][EXP_DEPTH];
    int        exp_cnt  [`PITO_NUM_HARTS];
    int        ret_cnt  [`PITO_NUM_HARTS];
    int        cycles;

    pito_core UUT (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .imem_w_en    (imem_w_en),
        .imem_addr    (imem_addr),
        .imem_data    (imem_data),
        .retire_valid (retire_valid),
        .retire_hart  (retire_hart),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    bind pito_core pito_core_properties u_props (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .retire_valid (retire_valid),
        .retire_hart  (retire_hart),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==============================
    // instruction encoders
    // ==============================

    function automatic instr_t r_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic instr_t i_word(logic [11:0] imm12, reg_addr_t rs1, logic [2:0] f3,
                                      reg_addr_t rd);
        return {imm12, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic instr_t lui_word(reg_addr_t rd, logic [19:0] imm20);
        return {imm20, rd, 7'b0110111};
    endfunction

    // b-type offset scrambling
    function automatic instr_t bne_word(reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], 7'b1100011};
    endfunction

    // j-type offset scrambling
    function automatic instr_t jal_word(reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ==============================
    // reference model
    // ==============================

    // op index 0..9 is add sub and or xor sll srl sra slt sltu
    function automatic logic [2:0] funct3_of(int a);
        case (a)
            0, 1:    return 3'b000;
            2:       return 3'b111;
            3:       return 3'b110;
            4:       return 3'b100;
            5:       return 3'b001;
            6, 7:    return 3'b101;
            8:       return 3'b010;
            default: return 3'b011;
        endcase
    endfunction

    // sub and sra carry bit 30
    function automatic logic [6:0] alt_f7(int a);
        return (a == 1 || a == 7) ? 7'h20 : 7'h00;
    endfunction

    function automatic xlen_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic xlen_t alu_ref(int a, xlen_t x, xlen_t y);
        case (a)
            0:       return x + y;
            1:       return x - y;
            2:       return x & y;
            3:       return x | y;
            4:       return x ^ y;
            5:       return x << y[4:0];
            6:       return x >> y[4:0];
            7:       return xlen_t'($signed(x) >>> y[4:0]);
            8:       return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            default: return (x < y) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // x0 or one of x6..x13
    function automatic reg_addr_t pick_src();
        int r;
        r = {$random(seed)} % 9;
        return (r == 0) ? reg_addr_t'(0) : reg_addr_t'(r + 5);
    endfunction

    function automatic logic all_retired();
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            if (ret_cnt[h] < exp_cnt[h]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_mismatch(string name, int h, xlen_t got, xlen_t exp);
        $display("ERR %0t %s hart %0d: got %h expected %h", $time, name, h, got, exp);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // ==============================
    // program generation
    // ==============================

    // one word per falling edge
    task automatic emit_word(instr_t w);
        @(negedge clk);
        imem_w_en = 1'b1;
        imem_addr = imem_addr_t'(gen_pc >> 2);
        imem_data = w;
        gen_pc    = gen_pc + 32'd4;
    endtask

    task automatic expect_retire(int h, pc_t pc, reg_addr_t rd, xlen_t data);
        exp_pc[h][exp_cnt[h]]   = pc;
        exp_rd[h][exp_cnt[h]]   = rd;
        exp_data[h][exp_cnt[h]] = data;
        exp_cnt[h]              = exp_cnt[h] + 1;
    endtask

    task automatic build_program(int h);
        logic [19:0] imm20;
        logic [11:0] imm12;
        logic [4:0]  shamt;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        xlen_t       op_b;
        xlen_t       res;
        instr_t      word;
        int          a;
        int          k;
        pc_t         loop_pc;
        gen_pc = pc_t'(h << `PITO_HART_BASE_SHIFT);
        for (int r = 0; r < 32; r++) begin
            mreg[r] = '0;
        end
        // seed x6..x13 with lui then addi
        for (int r = 6; r < 14; r++) begin
            imm20   = 20'($random(seed));
            imm12   = 12'($random(seed));
            mreg[r] = {imm20, 12'b0};
            expect_retire(h, gen_pc, reg_addr_t'(r), mreg[r]);
            emit_word(lui_word(reg_addr_t'(r), imm20));
            mreg[r] = mreg[r] + sext12(imm12);
            expect_retire(h, gen_pc, reg_addr_t'(r), mreg[r]);
            emit_word(i_word(imm12, reg_addr_t'(r), 3'b000, reg_addr_t'(r)));
        end
        // a write to x0 is dropped and never retires
        emit_word(i_word(12'h5a5, reg_addr_t'(6), 3'b000, reg_addr_t'(0)));
        // two passes of 10 reg-reg ops, 9 reg-imm ops and a lui
        for (int n = 0; n < 40; n++) begin
            k   = n % 20;
            rd  = reg_addr_t'(6 + {$random(seed)} % 8);
            rs1 = pick_src();
            rs2 = pick_src();
            if (k == 19) begin
                imm20 = 20'($random(seed));
                res   = {imm20, 12'b0};
                word  = lui_word(rd, imm20);
            end else begin
                if (k < 10) begin
                    a    = k;
                    op_b = mreg[rs2];
                    word = r_word(alt_f7(a), rs2, rs1, funct3_of(a), rd);
                end else begin
                    // k of 10 maps to addi as there is no subi
                    a = (k == 10) ? 0 : k - 9;
                    if (a == 5 || a == 6 || a == 7) begin
                        shamt = 5'($random(seed));
                        imm12 = {alt_f7(a), shamt};
                        op_b  = xlen_t'(shamt);
                    end else begin
                        imm12 = 12'($random(seed));
                        op_b  = sext12(imm12);
                    end
                    word = i_word(imm12, rs1, funct3_of(a), rd);
                end
                res = alu_ref(a, mreg[rs1], op_b);
            end
            expect_retire(h, gen_pc, rd, res);
            emit_word(word);
            mreg[rd] = res;
        end
        // countdown in x5 runs the body three times
        expect_retire(h, gen_pc, reg_addr_t'(5), 32'd3);
        emit_word(i_word(12'd3, reg_addr_t'(0), 3'b000, reg_addr_t'(5)));
        loop_pc = gen_pc;
        emit_word(i_word(12'hfff, reg_addr_t'(5), 3'b000, reg_addr_t'(5)));
        // back by one word
        emit_word(bne_word(reg_addr_t'(5), reg_addr_t'(0), 13'h1ffc));
        for (int v = 2; v >= 0; v--) begin
            expect_retire(h, loop_pc, reg_addr_t'(5), xlen_t'(v));
        end
        // jump to itself with the link in x1
        for (int j = 0; j < 3; j++) begin
            expect_retire(h, gen_pc, reg_addr_t'(1), gen_pc + 32'd4);
        end
        emit_word(jal_word(reg_addr_t'(1), 21'd0));
    endtask

    // ==============================
    // retire checks
    // ==============================

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        int h;
        int i;
        if (!rst && retire_valid) begin
            h = int'(retire_hart);
            i = ret_cnt[h];
            if (i < exp_cnt[h]) begin
                assert (retire_pc == exp_pc[h][i])
                    else report_mismatch("retire_pc", h, retire_pc, exp_pc[h][i]);
                assert (retire_rd == exp_rd[h][i])
                    else report_mismatch("retire_rd", h, xlen_t'(retire_rd),
                                         xlen_t'(exp_rd[h][i]));
                assert (retire_data == exp_data[h][i])
                    else report_mismatch("retire_data", h, retire_data, exp_data[h][i]);
            end
            ret_cnt[h] = i + 1;
        end
    end

    // bound property failures
    always @(negedge clk) begin
        if (UUT.u_props.assert_fails != 0) begin
            $display("a property on pito_core failed at %0t", $time);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    // ==============================
    // main sequence
    // ==============================

    initial begin
        rst       = 1'b1;
        run       = 1'b0;
        imem_w_en = 1'b0;
        imem_addr = '0;
        imem_data = '0;
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            exp_cnt[h] = 0;
            ret_cnt[h] = 0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        // load every hart region while held
        for (int h = 0; h < `PITO_NUM_HARTS; h++) begin
            build_program(h);
        end
        @(negedge clk);
        imem_w_en = 1'b0;
        repeat (8) @(negedge clk);
        run    = 1'b1;
        cycles = 0;
        while (!all_retired()) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("timeout: harts did not reach their last expected retire");
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
        end
        // a few more turns around the self jump
        repeat (4 * `PITO_NUM_HARTS) @(negedge clk);
        if (UUT.u_props.assert_fails == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hw/pito_pkg.sv
hw/pito_fetch.sv
hw/pito_decoder.sv
hw/pito_regfile.sv
hw/pito_execute.sv
hw/pito_core.sv
verif/pito_core_properties.sv
verif/pito_core_tb.sv
